// File: common/mips_pkg.sv
package mips_pkg;

    // one machine word: data, instruction or byte address
    typedef logic [31:0] word_t;
    // register number as found in the rs, rt and rd fields
    typedef logic [4:0] reg_idx_t;
    // raw 16-bit immediate of an i-type word
    typedef logic [15:0] imm_t;

    // primary opcode, instr[31:26], standard MIPS-I values
    typedef enum logic [5:0] {
        op_special = 6'b000000,
        op_j       = 6'b000010,
        op_beq     = 6'b000100,
        op_bne     = 6'b000101,
        op_addiu   = 6'b001001,
        op_lb      = 6'b100000,
        op_lw      = 6'b100011,
        op_sw      = 6'b101011
    } opcode_t;

    // function field of the special opcode, instr[5:0]
    typedef enum logic [5:0] {
        fn_jr   = 6'b001000,
        fn_addu = 6'b100001,
        fn_subu = 6'b100011
    } funct_t;

    // what the alu does with its two operands
    typedef enum logic [1:0] {
        alu_add   = 2'd0,
        alu_sub   = 2'd1,
        alu_passb = 2'd2
    } alu_op_t;

    // how the delay-slot next pc gets updated
    typedef enum logic [2:0] {
        br_none = 3'd0,
        br_beq  = 3'd1,
        br_bne  = 3'd2,
        br_j    = 3'd3,
        br_jr   = 3'd4
    } branch_kind_t;

    // reset vector, start of the rom region
    localparam word_t boot_addr = 32'hBFC00000;
    // reaching this pc ends the run
    localparam word_t halt_addr = 32'h00000000;
    localparam int iram_words = 4096;
    localparam int dram_bytes = 4096;

endpackage

// File: cpu/mips_alu.sv
`timescale 1ns/1ps

module mips_alu (
    input  mips_pkg::word_t   a,
    input  mips_pkg::word_t   b,
    input  mips_pkg::alu_op_t op,
    output mips_pkg::word_t   result,
    output logic              equal
);
    import mips_pkg::*;

    // no overflow trap, add and subtract just wrap
    always_comb begin
        case (op)
            alu_add:   result = a + b;
            alu_sub:   result = a - b;
            alu_passb: result = b;
            default:   result = a + b;
        endcase
    end

    // beq and bne look at this
    assign equal = (a == b);

endmodule

// File: cpu/mips_regfile.sv
`timescale 1ns/1ps

module mips_regfile (
    input  logic               clk,
    input  logic               rst_n,
    input  mips_pkg::reg_idx_t rs_idx,
    input  mips_pkg::reg_idx_t rt_idx,
    output mips_pkg::word_t    rs_data,
    output mips_pkg::word_t    rt_data,
    input  logic               wr_en,
    input  mips_pkg::reg_idx_t wr_idx,
    input  mips_pkg::word_t    wr_data,
    output mips_pkg::word_t    v0
);
    import mips_pkg::*;

    word_t regs [0:31];

    // writes to r0 are dropped
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_idx != '0)) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // async read, r0 hardwired to zero
    assign rs_data = (rs_idx == '0) ? '0 : regs[rs_idx];
    assign rt_data = (rt_idx == '0) ? '0 : regs[rt_idx];

    // observation tap on r2
    assign v0 = regs[2];

endmodule

// File: cpu/mips_decode.sv
`timescale 1ns/1ps

module mips_decode (
    input  mips_pkg::word_t        instr,
    output mips_pkg::alu_op_t      alu_op,
    output logic                   use_imm,
    output logic                   reg_write,
    output logic                   dst_is_rt,
    output logic                   mem_read,
    output logic                   mem_write,
    output logic                   mem_byte,
    output mips_pkg::branch_kind_t branch_kind
);
    import mips_pkg::*;

    opcode_t opcode;
    funct_t  funct;

    assign opcode = opcode_t'(instr[31:26]);
    assign funct  = funct_t'(instr[5:0]);

    always_comb begin
        // anything not listed below retires as a nop
        alu_op      = alu_add;
        use_imm     = 1'b0;
        reg_write   = 1'b0;
        dst_is_rt   = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        mem_byte    = 1'b0;
        branch_kind = br_none;

        case (opcode)
            op_special: begin
                case (funct)
                    fn_addu: reg_write = 1'b1;
                    fn_subu: begin
                        alu_op    = alu_sub;
                        reg_write = 1'b1;
                    end
                    fn_jr:   branch_kind = br_jr;
                    default: ;
                endcase
            end
            op_addiu: begin
                use_imm   = 1'b1;
                reg_write = 1'b1;
                dst_is_rt = 1'b1;
            end
            // loads and stores add the offset to the base in rs
            op_lb, op_lw: begin
                use_imm   = 1'b1;
                reg_write = 1'b1;
                dst_is_rt = 1'b1;
                mem_read  = 1'b1;
                mem_byte  = (opcode == op_lb);
            end
            op_sw: begin
                use_imm   = 1'b1;
                mem_write = 1'b1;
            end
            // branches subtract rs and rt, only the equal flag matters
            op_beq: begin
                alu_op      = alu_sub;
                branch_kind = br_beq;
            end
            op_bne: begin
                alu_op      = alu_sub;
                branch_kind = br_bne;
            end
            op_j:    branch_kind = br_j;
            default: ;
        endcase
    end

endmodule

// File: cpu/mips_cpu.sv
`timescale 1ns/1ps

module mips_cpu (
    input  logic            clk,
    input  logic            rst_n,
    output mips_pkg::word_t instr_address,
    input  mips_pkg::word_t instr_readdata,
    output mips_pkg::word_t data_address,
    output logic            data_write,
    output logic            data_read,
    output mips_pkg::word_t data_writedata,
    input  mips_pkg::word_t data_readdata,
    output logic            active,
    output mips_pkg::word_t register_v0
);
    import mips_pkg::*;

    // pc of the instruction executing now, npc of the one after it
    word_t pc;
    word_t npc;
    word_t npc_next;

    // decoder controls
    alu_op_t      alu_op;
    logic         use_imm;
    logic         reg_write;
    logic         dst_is_rt;
    logic         mem_read;
    logic         mem_write;
    logic         mem_byte;
    branch_kind_t branch_kind;

    // instruction fields
    reg_idx_t rs_idx;
    reg_idx_t rt_idx;
    reg_idx_t rd_idx;
    imm_t     imm;
    word_t    sext_imm;

    // datapath
    word_t    rs_data;
    word_t    rt_data;
    word_t    alu_b;
    word_t    alu_result;
    logic     equal;
    reg_idx_t wr_idx;
    word_t    wr_data;
    logic [7:0] load_byte;
    word_t    load_data;

    assign instr_address = pc;

    assign rs_idx   = instr_readdata[25:21];
    assign rt_idx   = instr_readdata[20:16];
    assign rd_idx   = instr_readdata[15:11];
    assign imm      = instr_readdata[15:0];
    assign sext_imm = {{16{imm[15]}}, imm};

    mips_decode u_decode (
        .instr       (instr_readdata),
        .alu_op      (alu_op),
        .use_imm     (use_imm),
        .reg_write   (reg_write),
        .dst_is_rt   (dst_is_rt),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .mem_byte    (mem_byte),
        .branch_kind (branch_kind)
    );

    // i-type results land in rt, r-type in rd
    assign wr_idx = dst_is_rt ? rt_idx : rd_idx;

    mips_regfile u_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_idx  (rs_idx),
        .rt_idx  (rt_idx),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wr_en   (reg_write & active),
        .wr_idx  (wr_idx),
        .wr_data (wr_data),
        .v0      (register_v0)
    );

    assign alu_b = use_imm ? sext_imm : rt_data;

    // branches compare rs with rt through the equal flag
    mips_alu u_alu (
        .a      (rs_data),
        .b      (alu_b),
        .op     (alu_op),
        .result (alu_result),
        .equal  (equal)
    );

    // memory side sees word addresses only
    assign data_address   = {alu_result[31:2], 2'b00};
    assign data_writedata = rt_data;
    // no strobes once halted
    assign data_write     = mem_write & active;
    assign data_read      = mem_read & active;

    // little-endian lane pick for lb, then sign extension
    assign load_byte = data_readdata[{alu_result[1:0], 3'b000} +: 8];
    assign load_data = mem_byte ? {{24{load_byte[7]}}, load_byte} : data_readdata;
    assign wr_data   = mem_read ? load_data : alu_result;

    // target for npc; npc itself is the delay slot address
    always_comb begin
        case (branch_kind)
            br_beq:  npc_next = equal ? npc + {sext_imm[29:0], 2'b00} : npc + 32'd4;
            br_bne:  npc_next = equal ? npc + 32'd4 : npc + {sext_imm[29:0], 2'b00};
            // j keeps the region bits of the delay slot
            br_j:    npc_next = {npc[31:28], instr_readdata[25:0], 2'b00};
            br_jr:   npc_next = rs_data;
            default: npc_next = npc + 32'd4;
        endcase
    end

    // active drops on the edge that loads halt_addr into pc, pc holds from then on
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc     <= boot_addr;
            npc    <= boot_addr + 32'd4;
            active <= 1'b1;
        end else if (active) begin
            pc     <= npc;
            npc    <= npc_next;
            active <= (npc != halt_addr);
        end
    end

endmodule

// File: memory/mips_iram.sv
`timescale 1ns/1ps

module mips_iram (
    input  mips_pkg::word_t instr_address,
    output mips_pkg::word_t instr_readdata
);
    import mips_pkg::*;

    word_t rom [0:iram_words-1];

    // field packers for the three encodings
    function automatic word_t i_type(opcode_t op, reg_idx_t rs, reg_idx_t rt, imm_t imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t r_type(funct_t fn, reg_idx_t rs, reg_idx_t rt, reg_idx_t rd);
        return {op_special, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t j_type(opcode_t op, logic [25:0] target);
        return {op, target};
    endfunction

    initial begin : load_program
        word_t w_addr;

        for (int i = 0; i < iram_words; i++) begin
            rom[i] = '0;
        end

        // w_addr is the offset from boot_addr, stepped by 4
        w_addr = '0;
        // r10 = 1000, r11 = 10
        rom[w_addr >> 2] = i_type(op_addiu, 5'd0, 5'd10, imm_t'(1000));
        w_addr += 4;
        rom[w_addr >> 2] = i_type(op_addiu, 5'd0, 5'd11, imm_t'(10));
        w_addr += 4;
        // r2..r5 = sign-extended bytes 8..11
        rom[w_addr >> 2] = i_type(op_lb, 5'd0, 5'd2, imm_t'(8));
        w_addr += 4;
        rom[w_addr >> 2] = i_type(op_lb, 5'd11, 5'd3, imm_t'(-1));
        w_addr += 4;
        rom[w_addr >> 2] = i_type(op_lb, 5'd11, 5'd4, imm_t'(0));
        w_addr += 4;
        rom[w_addr >> 2] = i_type(op_lb, 5'd11, 5'd5, imm_t'(1));
        w_addr += 4;
        // beq r0, r0 always taken, lands past the poison word
        rom[w_addr >> 2] = i_type(op_beq, 5'd0, 5'd0, imm_t'(2));
        w_addr += 4;
        // delay slot runs, r6 = 5
        rom[w_addr >> 2] = i_type(op_addiu, 5'd0, 5'd6, imm_t'(5));
        w_addr += 4;
        // poison, would wreck r6 and so the final r2
        rom[w_addr >> 2] = i_type(op_addiu, 5'd0, 5'd6, imm_t'(16'h7000));
        w_addr += 4;
        // bne r3, r3 never taken
        rom[w_addr >> 2] = i_type(op_bne, 5'd3, 5'd3, imm_t'(2));
        w_addr += 4;
        // delay slot, r6 = 8
        rom[w_addr >> 2] = i_type(op_addiu, 5'd6, 5'd6, imm_t'(3));
        w_addr += 4;
        // stores to 12, 16, 20 and 24
        rom[w_addr >> 2] = i_type(op_sw, 5'd10, 5'd2, imm_t'(-988));
        w_addr += 4;
        rom[w_addr >> 2] = i_type(op_sw, 5'd10, 5'd3, imm_t'(-984));
        w_addr += 4;
        rom[w_addr >> 2] = i_type(op_sw, 5'd11, 5'd4, imm_t'(10));
        w_addr += 4;
        rom[w_addr >> 2] = i_type(op_sw, 5'd11, 5'd5, imm_t'(14));
        w_addr += 4;
        // r2 = r4 + r6 = 0x87, then r2 - r3 = 0x85
        rom[w_addr >> 2] = r_type(fn_addu, 5'd4, 5'd6, 5'd2);
        w_addr += 4;
        rom[w_addr >> 2] = r_type(fn_subu, 5'd2, 5'd3, 5'd2);
        w_addr += 4;
        // jr r0 sends npc to address 0, which halts
        rom[w_addr >> 2] = r_type(fn_jr, 5'd0, 5'd0, 5'd0);
        w_addr += 4;
        // nop in the delay slot
        rom[w_addr >> 2] = '0;
        // spare j encoding, never reached, loops to boot
        w_addr += 4;
        rom[w_addr >> 2] = j_type(op_j, boot_addr[27:2]);
    end

    always_comb begin
        // inside the rom window of the boot region
        if ((instr_address[31:16] == boot_addr[31:16]) &&
            (instr_address[15:$clog2(iram_words)+2] == '0)) begin
            instr_readdata = rom[instr_address[$clog2(iram_words)+1:2]];
        end else begin
            // address 0 and everything unmapped fetch a nop
            instr_readdata = '0;
        end
    end

endmodule

// File: memory/mips_dram.sv
`timescale 1ns/1ps

module mips_dram (
    input  logic            clk,
    input  mips_pkg::word_t data_address,
    input  logic            data_write,
    input  logic            data_read,
    input  mips_pkg::word_t data_writedata,
    output mips_pkg::word_t data_readdata
);
    import mips_pkg::*;

    logic [7:0] mem [0:dram_bytes-1];

    // first byte of the addressed word, address wraps inside the array
    logic [$clog2(dram_bytes)-1:0] base;

    assign base = {data_address[$clog2(dram_bytes)-1:2], 2'b00};

    initial begin
        for (int i = 0; i < dram_bytes; i++) begin
            mem[i] = 8'h00;
        end
        // mix of negative and positive bytes for lb
        mem[8]  = 8'h81;
        mem[9]  = 8'h02;
        mem[10] = 8'h7f;
        mem[11] = 8'hf0;
    end

    // little endian, lowest address in bits 7:0
    always_ff @(posedge clk) begin
        if (data_write) begin
            mem[base]     <= data_writedata[7:0];
            mem[base + 1] <= data_writedata[15:8];
            mem[base + 2] <= data_writedata[23:16];
            mem[base + 3] <= data_writedata[31:24];
        end
    end

    // combinational read, zero when no load is asking
    assign data_readdata = data_read ?
        {mem[base + 3], mem[base + 2], mem[base + 1], mem[base]} : '0;

endmodule

// File: verilog/mips_sys.sv
`timescale 1ns/1ps

module mips_sys (
    input  logic            clk,
    input  logic            rst_n,
    output logic            active,
    output mips_pkg::word_t register_v0,
    output logic            data_write,
    output mips_pkg::word_t data_address,
    output mips_pkg::word_t data_writedata
);
    import mips_pkg::*;

    // fetch path, answered in the same cycle
    word_t instr_address;
    word_t instr_readdata;

    // load path, read strobe stays internal
    logic  data_read;
    word_t data_readdata;

    mips_cpu u_cpu (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr_address  (instr_address),
        .instr_readdata (instr_readdata),
        .data_address   (data_address),
        .data_write     (data_write),
        .data_read      (data_read),
        .data_writedata (data_writedata),
        .data_readdata  (data_readdata),
        .active         (active),
        .register_v0    (register_v0)
    );

    // rom with the branch test program
    mips_iram u_iram (
        .instr_address  (instr_address),
        .instr_readdata (instr_readdata)
    );

    // byte array with the preloaded lb test bytes
    mips_dram u_dram (
        .clk            (clk),
        .data_address   (data_address),
        .data_write     (data_write),
        .data_read      (data_read),
        .data_writedata (data_writedata),
        .data_readdata  (data_readdata)
    );

endmodule

// File: bench/mips_sys_tb.sv
`timescale 1ns/1ps

module mips_sys_tb;
    import mips_pkg::*;

    localparam int half_period  = 50;
    localparam int reset_cycles = 3;
    localparam int tail_cycles  = 10;
    localparam int n_stores     = 4;
    // full run, run cut by reset, full rerun
    localparam int n_runs       = 3;
    // boot word up to and including the nop behind jr r0
    // the poison word behind the beq delay slot never retires
    localparam int prog_instrs  = 18;
    localparam int run_cycles   = reset_cycles + 2 + prog_instrs + 20 + tail_cycles;

    logic  clk;
    logic  rst_n;
    logic  active;
    word_t register_v0;
    logic  data_write;
    word_t data_address;
    word_t data_writedata;

    // rising edges since the last reset release
    int edge_cnt;

    // expected stores in program order
    string store_name [0:n_stores-1];
    word_t store_addr [0:n_stores-1];
    word_t store_data [0:n_stores-1];
    // end-of-run results
    word_t final_v0;
    int    final_retired;

    mips_sys u_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .active         (active),
        .register_v0    (register_v0),
        .data_write     (data_write),
        .data_address   (data_address),
        .data_writedata (data_writedata)
    );

    always #half_period clk = ~clk;

    function automatic word_t sext_byte(input logic [7:0] b);
        return {{24{b[7]}}, b};
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            report_failure($sformatf("mismatch %s: expected %08h, actual %08h", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            report_failure($sformatf("mismatch %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic build_table();
        logic [7:0] init_bytes [0:3];
        word_t      r6;

        // data ram bytes 8..11
        init_bytes[0] = 8'h81;
        init_bytes[1] = 8'h02;
        init_bytes[2] = 8'h7f;
        init_bytes[3] = 8'hf0;
        // lb fills r2..r5 with bytes 8..11, sw puts them at 12..24
        for (int i = 0; i < n_stores; i++) begin
            store_name[i] = $sformatf("sw_r%0d", i + 2);
            store_addr[i] = word_t'(12 + 4 * i);
            store_data[i] = sext_byte(init_bytes[i]);
        end
        // beq delay slot sets 5, bne fall-through adds 3, poison never runs
        r6 = 32'd5 + 32'd3;
        // addu r2 = r4 + r6, then subu r2 = r2 - r3
        final_v0 = sext_byte(init_bytes[2]) + r6 - sext_byte(init_bytes[1]);
        final_retired = prog_instrs;
    endtask

    // one rising edge, then look at the outputs half a period later
    task automatic step_cycle();
        @(posedge clk);
        edge_cnt++;
        @(negedge clk);
    endtask

    task automatic apply_reset(input string run_name);
        @(posedge clk);
        #1 rst_n = 1'b0;
        repeat (reset_cycles) begin
            @(negedge clk);
            check_flag({run_name, " reset active"}, 1'b1, active);
            check_flag({run_name, " reset data_write"}, 1'b0, data_write);
            check_word({run_name, " reset v0"}, '0, register_v0);
            @(posedge clk);
        end
        #1 rst_n = 1'b1;
        edge_cnt = 0;
    endtask

    // steps until a store strobe is seen, gives up after limit edges
    task automatic wait_store(input string name, input int limit);
        int waited;

        waited = 0;
        step_cycle();
        waited++;
        while (data_write !== 1'b1) begin
            if (waited >= limit) begin
                report_failure($sformatf("%s: no store strobe within %0d cycles", name, limit));
            end
            step_cycle();
            waited++;
        end
    endtask

    task automatic wait_halt(input string name, input int limit);
        while (active !== 1'b0) begin
            if (edge_cnt >= limit) begin
                report_failure($sformatf("%s: core still active after %0d cycles", name, limit));
            end
            step_cycle();
        end
    endtask

    // store_limit below n_stores leaves the program running for the next reset
    task automatic run_program(input string run_name, input int store_limit);
        string tag;

        apply_reset(run_name);
        // first edge after release retires the boot word
        step_cycle();
        check_flag({run_name, " first edge active"}, 1'b1, active);
        check_flag({run_name, " first edge data_write"}, 1'b0, data_write);

        for (int i = 0; i < store_limit; i++) begin
            tag = {run_name, " ", store_name[i]};
            wait_store(tag, prog_instrs + 20);
            check_word({tag, " address"}, store_addr[i], data_address);
            check_word({tag, " data"}, store_data[i], data_writedata);
        end

        if (store_limit == n_stores) begin
            wait_halt(run_name, prog_instrs + 20);
            // active must drop on the edge that retires the last nop
            check_word({run_name, " retired"}, word_t'(final_retired), word_t'(edge_cnt));
            check_word({run_name, " register_v0"}, final_v0, register_v0);
            repeat (tail_cycles) begin
                step_cycle();
                check_flag({run_name, " halted data_write"}, 1'b0, data_write);
                check_flag({run_name, " halted active"}, 1'b0, active);
            end
        end
    endtask

    // watchdog sized from the runs
    initial begin
        repeat (n_runs * run_cycles) @(posedge clk);
        report_failure("watchdog expired, simulation did not finish in time");
    end

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        edge_cnt = 0;
        build_table();

        run_program("run1", n_stores);
        // reset lands one cycle after the second store
        run_program("cut", 2);
        run_program("run2", n_stores);

        $display("TEST OK");
        $finish;
    end

endmodule

// File: project.f
common/mips_pkg.sv
cpu/mips_alu.sv
cpu/mips_regfile.sv
cpu/mips_decode.sv
cpu/mips_cpu.sv
memory/mips_iram.sv
memory/mips_dram.sv
verilog/mips_sys.sv
bench/mips_sys_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
    --top-module mips_sys_tb -f project.f -o mips_sys_tb_sim
./obj_dir/mips_sys_tb_sim 2>&1 | tee sim.log

if grep -qx "TEST OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
